// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, then decide from the simulation log
verilator --binary --timing --assert -f tb.f --top-module tb_twin_buffer -o sim_tb \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "simulator exited with an error" >> sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL, see sim.log"; exit 1; }

// File: src/bank_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module bank_ctrl
  import twin_buf_pkg::*;
#(
  parameter int DEPTH           = 16,
  parameter int WORD_W          = 15,
  parameter int WORDS_PER_ENTRY = 2
)
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wr,
  input  logic                              wr_done,
  input  logic [$clog2(DEPTH)-1:0]          wr_addr,
  input  logic [WORDS_PER_ENTRY-1:0]        wr_valid_word,
  input  logic [WORDS_PER_ENTRY*WORD_W-1:0] wr_data,
  input  logic [SEQ_ID_W-1:0]               wr_seq_id,
  input  logic                              rd,
  input  logic [$clog2(DEPTH)-1:0]          rd_addr,
  input  logic [SEQ_ID_W-1:0]               rd_seq_id,
  input  logic                              rd_done,
  output logic                              full,
  output logic                              rd_hit,
  output logic [WORDS_PER_ENTRY-1:0]        rd_tag_valid,
  buf_mem_if.ctrl                           mem
);

  localparam int RAM_AW = $clog2(2 * DEPTH);

  bank_state_t                           bank_st [2];
  bank_state_t                           bank_nxt [2];
  logic [SEQ_ID_W-1:0]                   seq_tag [2];
  logic [DEPTH-1:0][WORDS_PER_ENTRY-1:0] word_val [2];
  logic [RAM_AW-1:0]                     init_addr;
  logic                                  init_active;
  logic                                  wr_valid;
  logic [1:0]                            wr_bank;
  logic [1:0]                            rd_bank;
  logic [1:0]                            release_bank;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bank state machines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign init_active = (bank_st[0] == BANK_INIT) || (bank_st[1] == BANK_INIT);
  assign wr_valid    = wr && (wr_valid_word != '0) && !init_active;

  // bank 0 opens unless bank 1 is mid-frame, bank 1 only once bank 0 has filled
  assign wr_bank[0] = wr_valid && ((bank_st[0] == BANK_WR) ||
                      (bank_st[0] == BANK_IDLE && bank_st[1] != BANK_WR));
  assign wr_bank[1] = wr_valid && ((bank_st[1] == BANK_WR) ||
                      (bank_st[1] == BANK_IDLE && bank_st[0] == BANK_FULL));

  always_comb
  begin
    for (int b = 0; b < 2; b++)
    begin
      rd_bank[b]      = rd && (bank_st[b] == BANK_FULL) && (rd_seq_id == seq_tag[b]);
      release_bank[b] = rd_done && (bank_st[b] == BANK_FULL) && (rd_seq_id == seq_tag[b]);
      bank_nxt[b]     = bank_st[b];
      case (bank_st[b])
        BANK_INIT:
          if (init_addr == RAM_AW'((b + 1) * DEPTH - 1))
            bank_nxt[b] = BANK_IDLE;
        BANK_IDLE:
          if (wr_bank[b])
            bank_nxt[b] = wr_done ? BANK_FULL : BANK_WR;
        BANK_WR:
          if (wr_done)
            bank_nxt[b] = BANK_FULL;
        BANK_FULL:
          if (release_bank[b])
            bank_nxt[b] = BANK_IDLE;
        default:
          bank_nxt[b] = BANK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bank_st   <= '{default: BANK_INIT};
      word_val  <= '{default: '0};
      init_addr <= '0;
    end
    else
    begin
      // sweep runs until the top of bank 1 is cleared
      if (bank_st[1] == BANK_INIT)
        init_addr <= init_addr + 1'b1;
      for (int b = 0; b < 2; b++)
      begin
        bank_st[b] <= bank_nxt[b];
        if (wr_bank[b])
          word_val[b][wr_addr] <= word_val[b][wr_addr] | wr_valid_word;
        else if (release_bank[b])
          word_val[b] <= '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int b = 0; b < 2; b++)
    begin
      if (wr_bank[b])
        seq_tag[b] <= wr_seq_id;
    end
  end

  assign full = (bank_st[0] == BANK_FULL) && (bank_st[1] == BANK_FULL);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RAM port steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    mem.we = init_active || (wr_bank != 2'b00);
    if (init_active)
      mem.waddr = init_addr;
    else if (wr_bank[0])
      mem.waddr = RAM_AW'(wr_addr);
    else
      mem.waddr = RAM_AW'(wr_addr) + RAM_AW'(DEPTH);
    mem.wdata = init_active ? '0 : wr_data;
    for (int i = 0; i < WORDS_PER_ENTRY; i++)
      mem.bwe[i*WORD_W +: WORD_W] = {WORD_W{init_active || wr_valid_word[i]}};
  end

  always_comb
  begin
    rd_hit    = |rd_bank;
    mem.re    = rd_hit;
    mem.raddr = rd_bank[0] ? RAM_AW'(rd_addr) : RAM_AW'(rd_addr) + RAM_AW'(DEPTH);
    if (rd_bank[0])
      rd_tag_valid = word_val[0][rd_addr];
    else if (rd_bank[1])
      rd_tag_valid = word_val[1][rd_addr];
    else
      rd_tag_valid = '0;
  end

endmodule

`default_nettype wire

// File: src/buf_mem_if.sv
`timescale 1ns/100ps
`default_nettype none

interface buf_mem_if
#(
  parameter int DEPTH           = 16,
  parameter int WORD_W          = 15,
  parameter int WORDS_PER_ENTRY = 2
)
();

  localparam int DATA_W = WORDS_PER_ENTRY * WORD_W;
  // both banks share one RAM, bank 1 sits above bank 0
  localparam int ADDR_W = $clog2(2 * DEPTH);

  // write port
  logic              we;
  logic [ADDR_W-1:0] waddr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] bwe;

  // read port
  logic              re;
  logic [ADDR_W-1:0] raddr;
  logic [DATA_W-1:0] rdata;

  modport ctrl (output we, waddr, wdata, bwe, re, raddr);
  modport ram  (input we, waddr, wdata, bwe, re, raddr, output rdata);
  modport sink (input rdata);

endinterface

`default_nettype wire

// File: src/buf_ram.sv
`timescale 1ns/100ps
`default_nettype none

module buf_ram
#(
  parameter int DEPTH           = 16,
  parameter int WORD_W          = 15,
  parameter int WORDS_PER_ENTRY = 2
)
(
  input  logic   clk,
  buf_mem_if.ram mem
);

  localparam int DATA_W = WORDS_PER_ENTRY * WORD_W;

  logic [DATA_W-1:0] ram [2*DEPTH];

  // bit-masked write, untouched bits keep their old value
  always_ff @(posedge clk)
  begin
    if (mem.we)
      ram[mem.waddr] <= (ram[mem.waddr] & ~mem.bwe) | (mem.wdata & mem.bwe);
  end

  // one cycle read, output holds between reads
  always_ff @(posedge clk)
  begin
    if (mem.re)
      mem.rdata <= ram[mem.raddr];
  end

endmodule

`default_nettype wire

// File: src/meta_slots.sv
`timescale 1ns/100ps
`default_nettype none

module meta_slots
  import twin_buf_pkg::*;
#(
  parameter int META_W = 8
)
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_meta,
  input  logic                wr_meta_done,
  input  logic [META_W-1:0]   wr_meta_data,
  input  logic [SEQ_ID_W-1:0] wr_seq_id,
  input  logic [SEQ_ID_W-1:0] rd_seq_id,
  input  logic                rd_meta_done,
  output logic                meta_full,
  output logic [META_W-1:0]   rd_meta_data,
  output logic                rd_meta_vld
);

  meta_state_t         slot_st [2];
  meta_state_t         slot_nxt [2];
  logic [META_W-1:0]   slot_data [2];
  logic [SEQ_ID_W-1:0] slot_seq [2];
  logic [1:0]          wr_slot;
  logic [1:0]          release_slot;

  // same ping-pong order as the data banks
  assign wr_slot[0] = wr_meta && ((slot_st[0] == META_WR) ||
                      (slot_st[0] == META_IDLE && slot_st[1] != META_WR));
  assign wr_slot[1] = wr_meta && ((slot_st[1] == META_WR) ||
                      (slot_st[1] == META_IDLE && slot_st[0] == META_FULL));

  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      release_slot[s] = rd_meta_done && (slot_st[s] == META_FULL) &&
                        (rd_seq_id == slot_seq[s]);
      slot_nxt[s]     = slot_st[s];
      case (slot_st[s])
        META_IDLE:
          if (wr_slot[s])
            slot_nxt[s] = wr_meta_done ? META_FULL : META_WR;
        META_WR:
          if (wr_meta_done)
            slot_nxt[s] = META_FULL;
        META_FULL:
          if (release_slot[s])
            slot_nxt[s] = META_IDLE;
        default:
          slot_nxt[s] = META_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      slot_st <= '{default: META_IDLE};
    else
      slot_st <= slot_nxt;
  end

  always_ff @(posedge clk)
  begin
    for (int s = 0; s < 2; s++)
    begin
      if (wr_slot[s])
      begin
        slot_data[s] <= wr_meta_data;
        slot_seq[s]  <= wr_seq_id;
      end
    end
  end

  assign meta_full = (slot_st[0] == META_FULL) && (slot_st[1] == META_FULL);

  // lookup by sequence id, slot 0 first
  always_comb
  begin
    if (slot_st[0] == META_FULL && slot_seq[0] == rd_seq_id)
    begin
      rd_meta_data = slot_data[0];
      rd_meta_vld  = 1'b1;
    end
    else if (slot_st[1] == META_FULL && slot_seq[1] == rd_seq_id)
    begin
      rd_meta_data = slot_data[1];
      rd_meta_vld  = 1'b1;
    end
    else
    begin
      rd_meta_data = '0;
      rd_meta_vld  = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/rd_align.sv
`timescale 1ns/100ps
`default_nettype none

module rd_align
#(
  parameter int WORD_W          = 15,
  parameter int WORDS_PER_ENTRY = 2
)
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              rd_hit,
  input  logic [WORDS_PER_ENTRY-1:0]        rd_tag_valid,
  buf_mem_if.sink                           mem,
  output logic [WORDS_PER_ENTRY*WORD_W-1:0] rd_out,
  output logic [WORDS_PER_ENTRY-1:0]        rd_valid_word
);

  logic                       hit_q;
  logic [WORDS_PER_ENTRY-1:0] valid_q;

  // tag stage lines up with the RAM output register
  // second stage forms the outputs and zeroes the data on a miss
  // valid bits arrive already cleared for a miss
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hit_q         <= 1'b0;
      valid_q       <= '0;
      rd_out        <= '0;
      rd_valid_word <= '0;
    end
    else
    begin
      hit_q         <= rd_hit;
      valid_q       <= rd_tag_valid;
      rd_out        <= hit_q ? mem.rdata : '0;
      rd_valid_word <= valid_q;
    end
  end

endmodule

`default_nettype wire

// File: src/twin_buf_pkg.sv
`default_nettype none

package twin_buf_pkg;

  // frame sequence id carried with every entry and metadata word
  localparam int SEQ_ID_W = 4;

  // edges from a read request to rd_out / rd_valid_word
  localparam int RD_LATENCY = 2;

  typedef enum logic [1:0]
  {
    BANK_INIT,
    BANK_IDLE,
    BANK_WR,
    BANK_FULL
  } bank_state_t;

  typedef enum logic [1:0]
  {
    META_IDLE,
    META_WR,
    META_FULL
  } meta_state_t;

endpackage

`default_nettype wire

// File: src/twin_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module twin_buffer
  import twin_buf_pkg::*;
#(
  parameter int DEPTH           = 16,
  parameter int WORD_W          = 15,
  parameter int WORDS_PER_ENTRY = 2,
  parameter int META_W          = 8
)
(
  input  logic                              clk,
  input  logic                              rst_n,
  // write side
  input  logic                              wr,
  input  logic                              wr_done,
  input  logic [$clog2(DEPTH)-1:0]          wr_addr,
  input  logic [WORDS_PER_ENTRY*WORD_W-1:0] wr_data,
  input  logic [WORDS_PER_ENTRY-1:0]        wr_valid_word,
  input  logic [SEQ_ID_W-1:0]               wr_seq_id,
  input  logic                              wr_meta,
  input  logic                              wr_meta_done,
  input  logic [META_W-1:0]                 wr_meta_data,
  // read side
  input  logic                              rd,
  input  logic [$clog2(DEPTH)-1:0]          rd_addr,
  input  logic [SEQ_ID_W-1:0]               rd_seq_id,
  input  logic                              rd_done,
  input  logic                              rd_meta_done,
  // status and read data
  output logic                              full,
  output logic                              meta_full,
  output logic [WORDS_PER_ENTRY*WORD_W-1:0] rd_out,
  output logic [WORDS_PER_ENTRY-1:0]        rd_valid_word,
  output logic [META_W-1:0]                 rd_meta_data,
  output logic                              rd_meta_vld
);

  logic                       rd_hit;
  logic [WORDS_PER_ENTRY-1:0] rd_tag_valid;

  buf_mem_if #(
    .DEPTH           (DEPTH),
    .WORD_W          (WORD_W),
    .WORDS_PER_ENTRY (WORDS_PER_ENTRY)
  ) mem_if ();

  bank_ctrl #(
    .DEPTH           (DEPTH),
    .WORD_W          (WORD_W),
    .WORDS_PER_ENTRY (WORDS_PER_ENTRY)
  ) bank_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr            (wr),
    .wr_done       (wr_done),
    .wr_addr       (wr_addr),
    .wr_valid_word (wr_valid_word),
    .wr_data       (wr_data),
    .wr_seq_id     (wr_seq_id),
    .rd            (rd),
    .rd_addr       (rd_addr),
    .rd_seq_id     (rd_seq_id),
    .rd_done       (rd_done),
    .full          (full),
    .rd_hit        (rd_hit),
    .rd_tag_valid  (rd_tag_valid),
    .mem           (mem_if)
  );

  buf_ram #(
    .DEPTH           (DEPTH),
    .WORD_W          (WORD_W),
    .WORDS_PER_ENTRY (WORDS_PER_ENTRY)
  ) buf_ram_inst (
    .clk (clk),
    .mem (mem_if)
  );

  rd_align #(
    .WORD_W          (WORD_W),
    .WORDS_PER_ENTRY (WORDS_PER_ENTRY)
  ) rd_align_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_hit        (rd_hit),
    .rd_tag_valid  (rd_tag_valid),
    .mem           (mem_if),
    .rd_out        (rd_out),
    .rd_valid_word (rd_valid_word)
  );

  meta_slots #(
    .META_W (META_W)
  ) meta_slots_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_meta      (wr_meta),
    .wr_meta_done (wr_meta_done),
    .wr_meta_data (wr_meta_data),
    .wr_seq_id    (wr_seq_id),
    .rd_seq_id    (rd_seq_id),
    .rd_meta_done (rd_meta_done),
    .meta_full    (meta_full),
    .rd_meta_data (rd_meta_data),
    .rd_meta_vld  (rd_meta_vld)
  );

endmodule

`default_nettype wire

// File: tb.f
src/twin_buf_pkg.sv
src/buf_mem_if.sv
src/bank_ctrl.sv
src/buf_ram.sv
src/rd_align.sv
src/meta_slots.sv
src/twin_buffer.sv
verif/twin_buffer_assertions.sv
verif/tb_twin_buffer.sv

// File: verif/tb_twin_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_twin_buffer
  import twin_buf_pkg::*;
();

  localparam int DEPTH           = 16;
  localparam int WORD_W          = 15;
  localparam int WORDS_PER_ENTRY = 2;
  localparam int META_W          = 8;
  localparam int DATA_W          = WORDS_PER_ENTRY * WORD_W;
  localparam int AW              = $clog2(DEPTH);
  localparam int NUM_FRAMES      = 3;
  localparam int WAIT_LIMIT      = 50;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       wr;
  logic                       wr_done;
  logic [AW-1:0]              wr_addr;
  logic [DATA_W-1:0]          wr_data;
  logic [WORDS_PER_ENTRY-1:0] wr_valid_word;
  logic [SEQ_ID_W-1:0]        wr_seq_id;
  logic                       wr_meta;
  logic                       wr_meta_done;
  logic [META_W-1:0]          wr_meta_data;
  logic                       rd;
  logic [AW-1:0]              rd_addr;
  logic [SEQ_ID_W-1:0]        rd_seq_id;
  logic                       rd_done;
  logic                       rd_meta_done;
  logic                       full;
  logic                       meta_full;
  logic [DATA_W-1:0]          rd_out;
  logic [WORDS_PER_ENTRY-1:0] rd_valid_word;
  logic [META_W-1:0]          rd_meta_data;
  logic                       rd_meta_vld;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame table and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [SEQ_ID_W-1:0]        frame_seq  [NUM_FRAMES];
  int                         frame_bank [NUM_FRAMES];
  logic [META_W-1:0]          frame_meta [NUM_FRAMES];
  logic [WORDS_PER_ENTRY-1:0] frame_mask [NUM_FRAMES][DEPTH];
  logic [DATA_W-1:0]          frame_data [NUM_FRAMES][DEPTH];
  logic [DATA_W-1:0]          model_ram   [2*DEPTH];
  logic [WORDS_PER_ENTRY-1:0] model_valid [2*DEPTH];

  int test_errs = 0;
  int pass_cnt  = 0;
  int fail_cnt  = 0;

  always #5 clk = ~clk;

  twin_buffer #(
    .DEPTH           (DEPTH),
    .WORD_W          (WORD_W),
    .WORDS_PER_ENTRY (WORDS_PER_ENTRY),
    .META_W          (META_W)
  ) twin_buffer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr            (wr),
    .wr_done       (wr_done),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_valid_word (wr_valid_word),
    .wr_seq_id     (wr_seq_id),
    .wr_meta       (wr_meta),
    .wr_meta_done  (wr_meta_done),
    .wr_meta_data  (wr_meta_data),
    .rd            (rd),
    .rd_addr       (rd_addr),
    .rd_seq_id     (rd_seq_id),
    .rd_done       (rd_done),
    .rd_meta_done  (rd_meta_done),
    .full          (full),
    .meta_full     (meta_full),
    .rd_out        (rd_out),
    .rd_valid_word (rd_valid_word),
    .rd_meta_data  (rd_meta_data),
    .rd_meta_vld   (rd_meta_vld)
  );

  bind twin_buffer twin_buffer_assertions #(
    .DEPTH           (DEPTH),
    .WORDS_PER_ENTRY (WORDS_PER_ENTRY)
  ) assertions_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .bank_st0      (bank_ctrl_inst.bank_st[0]),
    .bank_st1      (bank_ctrl_inst.bank_st[1]),
    .we            (mem_if.we),
    .waddr         (mem_if.waddr),
    .rd_hit        (rd_hit),
    .rd_valid_word (rd_valid_word)
  );

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0)
    begin
      pass_cnt++;
      $display("test %s: pass", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: fail with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic wait_flag(input bit use_meta, input logic want, input string name);
    int cycles;
    cycles = 0;
    while (((use_meta ? meta_full : full) !== want) && (cycles < WAIT_LIMIT))
    begin
      @(negedge clk);
      cycles++;
    end
    if ((use_meta ? meta_full : full) !== want)
    begin
      $display("timeout: %s did not reach %0d within %0d cycles", name, want, WAIT_LIMIT);
      test_errs++;
    end
  endtask

  task automatic build_table();
    // bank column follows the ping-pong order, seq 3 reuses the bank freed by seq 1
    frame_seq  = '{4'd1, 4'd2, 4'd3};
    frame_bank = '{0, 1, 0};
    frame_meta = '{8'ha5, 8'h3c, 8'h71};
    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      for (int a = 0; a < DEPTH; a++)
      begin
        frame_data[f][a] = DATA_W'($urandom);
        frame_mask[f][a] = WORDS_PER_ENTRY'($urandom % 4);
      end
      // entry 0 always opens the bank and leaves word 1 unwritten
      frame_mask[f][0] = 2'b01;
    end
    for (int i = 0; i < 2 * DEPTH; i++)
    begin
      model_ram[i]   = '0;
      model_valid[i] = '0;
    end
  endtask

  task automatic write_frame(input int f);
    int idx;
    for (int a = 0; a < DEPTH; a++)
    begin
      @(negedge clk);
      wr            = 1'b1;
      wr_done       = (a == DEPTH - 1);
      wr_addr       = AW'(a);
      wr_data       = frame_data[f][a];
      wr_valid_word = frame_mask[f][a];
      wr_seq_id     = frame_seq[f];
      idx           = frame_bank[f] * DEPTH + a;
      for (int i = 0; i < WORDS_PER_ENTRY; i++)
        if (frame_mask[f][a][i])
          model_ram[idx][i*WORD_W +: WORD_W] = frame_data[f][a][i*WORD_W +: WORD_W];
      model_valid[idx] = model_valid[idx] | frame_mask[f][a];
    end
    @(negedge clk);
    wr            = 1'b0;
    wr_done       = 1'b0;
    wr_valid_word = '0;
  endtask

  task automatic read_entry(input logic [SEQ_ID_W-1:0] seq, input int addr,
                            output logic [DATA_W-1:0] data,
                            output logic [WORDS_PER_ENTRY-1:0] valid);
    @(negedge clk);
    rd        = 1'b1;
    rd_addr   = AW'(addr);
    rd_seq_id = seq;
    for (int i = 0; i < RD_LATENCY; i++)
    begin
      @(negedge clk);
      rd = 1'b0;
    end
    data  = rd_out;
    valid = rd_valid_word;
  endtask

  // back-to-back reads, each result checked RD_LATENCY cycles after its request
  task automatic read_frame(input int f, input bit descending, input bit hit);
    int                         addr_q[$];
    int                         a;
    logic [DATA_W-1:0]          exp_d;
    logic [WORDS_PER_ENTRY-1:0] exp_v;
    for (int i = 0; i < DEPTH + RD_LATENCY; i++)
    begin
      @(negedge clk);
      if (i >= RD_LATENCY)
      begin
        a     = addr_q.pop_front();
        exp_d = hit ? model_ram[frame_bank[f] * DEPTH + a] : '0;
        exp_v = hit ? model_valid[frame_bank[f] * DEPTH + a] : '0;
        compare_value("rd_out", 32'(exp_d), 32'(rd_out));
        compare_value("rd_valid_word", 32'(exp_v), 32'(rd_valid_word));
      end
      if (i < DEPTH)
      begin
        a         = descending ? DEPTH - 1 - i : i;
        rd        = 1'b1;
        rd_addr   = AW'(a);
        rd_seq_id = frame_seq[f];
        addr_q.push_back(a);
      end
      else
        rd = 1'b0;
    end
  endtask

  task automatic release_frame(input int f);
    @(negedge clk);
    rd_done   = 1'b1;
    rd_seq_id = frame_seq[f];
    for (int i = 0; i < DEPTH; i++)
      model_valid[frame_bank[f] * DEPTH + i] = '0;
    @(negedge clk);
    rd_done = 1'b0;
  endtask

  task automatic write_meta(input int f);
    @(negedge clk);
    wr_meta      = 1'b1;
    wr_meta_done = 1'b1;
    wr_meta_data = frame_meta[f];
    wr_seq_id    = frame_seq[f];
    @(negedge clk);
    wr_meta      = 1'b0;
    wr_meta_done = 1'b0;
  endtask

  task automatic check_meta(input logic [SEQ_ID_W-1:0] seq, input logic exp_vld,
                            input logic [META_W-1:0] exp_data);
    @(negedge clk);
    rd_seq_id = seq;
    @(negedge clk);
    compare_value("rd_meta_vld", 32'(exp_vld), 32'(rd_meta_vld));
    if (exp_vld)
      compare_value("rd_meta_data", 32'(exp_data), 32'(rd_meta_data));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    int                         seed_dummy;
    logic [DATA_W-1:0]          d;
    logic [WORDS_PER_ENTRY-1:0] v;
    seed_dummy    = $urandom(22);
    rst_n         = 1'b0;
    wr            = 1'b0;
    wr_done       = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    wr_valid_word = '0;
    wr_seq_id     = '0;
    wr_meta       = 1'b0;
    wr_meta_done  = 1'b0;
    wr_meta_data  = '0;
    rd            = 1'b0;
    rd_addr       = '0;
    rd_seq_id     = '0;
    rd_done       = 1'b0;
    rd_meta_done  = 1'b0;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    compare_value("full", 32'(1'b0), 32'(full));
    compare_value("meta_full", 32'(1'b0), 32'(meta_full));
    compare_value("rd_meta_vld", 32'(1'b0), 32'(rd_meta_vld));
    compare_value("rd_valid_word", 32'(1'b0), 32'(rd_valid_word));
    // init sweep clears both banks first
    repeat (2 * DEPTH + 2) @(negedge clk);
    read_entry(4'd5, 3, d, v);
    compare_value("rd_out", 32'(1'b0), 32'(d));
    compare_value("rd_valid_word", 32'(1'b0), 32'(v));
    finish_test("reset state");

    write_frame(0);
    compare_value("full", 32'(1'b0), 32'(full));
    write_frame(1);
    wait_flag(1'b0, 1'b1, "full");
    read_frame(0, 1'b0, 1'b1);
    read_frame(1, 1'b0, 1'b1);
    finish_test("two frames write and read");

    read_entry(frame_seq[0], 0, d, v);
    compare_value("rd_out word 0", 32'(frame_data[0][0][WORD_W-1:0]), 32'(d[WORD_W-1:0]));
    compare_value("rd_out word 1", 32'(1'b0), 32'(d[DATA_W-1:WORD_W]));
    compare_value("rd_valid_word", 32'(2'b01), 32'(v));
    finish_test("unwritten words are zero");

    release_frame(0);
    wait_flag(1'b0, 1'b0, "full");
    write_frame(2);
    wait_flag(1'b0, 1'b1, "full");
    read_frame(2, 1'b0, 1'b1);
    read_frame(0, 1'b0, 1'b0);
    finish_test("release and refill bank");

    write_meta(0);
    write_meta(1);
    wait_flag(1'b1, 1'b1, "meta_full");
    check_meta(frame_seq[0], 1'b1, frame_meta[0]);
    check_meta(frame_seq[1], 1'b1, frame_meta[1]);
    check_meta(4'd9, 1'b0, '0);
    @(negedge clk);
    rd_meta_done = 1'b1;
    rd_seq_id    = frame_seq[0];
    @(negedge clk);
    rd_meta_done = 1'b0;
    wait_flag(1'b1, 1'b0, "meta_full");
    finish_test("metadata slots");

    read_frame(1, 1'b1, 1'b1);
    finish_test("pipelined reads");

    if (twin_buffer_inst.assertions_inst.assert_fail_cnt != 0)
    begin
      $display("bound assertions failed %0d times",
               twin_buffer_inst.assertions_inst.assert_fail_cnt);
      fail_cnt++;
    end
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/twin_buffer_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module twin_buffer_assertions
  import twin_buf_pkg::*;
#(
  parameter int DEPTH           = 16,
  parameter int WORDS_PER_ENTRY = 2
)
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  bank_state_t                       bank_st0,
  input  bank_state_t                       bank_st1,
  input  logic                              we,
  input  logic [$clog2(2*DEPTH)-1:0]        waddr,
  input  logic                              rd_hit,
  input  logic [WORDS_PER_ENTRY-1:0]        rd_valid_word
);

  int assert_fail_cnt = 0;

  // ping-pong order keeps at most one bank mid-frame
  one_writer: assert property (@(posedge clk) disable iff (!rst_n)
    !(bank_st0 == BANK_WR && bank_st1 == BANK_WR))
  else
  begin
    $error("both banks in BANK_WR");
    assert_fail_cnt++;
  end

  // a full bank is frozen until its frame is released
  no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> ((int'(waddr) < DEPTH) ? (bank_st0 != BANK_FULL) : (bank_st1 != BANK_FULL)))
  else
  begin
    $error("RAM write into a bank in BANK_FULL");
    assert_fail_cnt++;
  end

  // miss two edges back leaves no valid word set
  miss_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(rd_hit, 2) |-> (rd_valid_word == '0))
  else
  begin
    $error("rd_valid_word not zero after a miss");
    assert_fail_cnt++;
  end

endmodule

`default_nettype wire
